// ==== bench/exec_stage_properties.sv ====
`timescale 1ns/100ps

module exec_stage_properties (
    input logic i_clk,
    input logic i_rst,
    input logic i_next_ready,
    input logic i_flush_in,
    input logic i_instr_valid,
    input logic i_raw_hazard,
    input logic i_flush_out
);

    // Misprediction flush is a single-cycle pulse
    assert property (@(posedge i_clk) disable iff (i_rst) i_flush_out |=> !i_flush_out)
        else $error("flush lasted more than one cycle");

    // Back-pressure keeps the waiting instruction
    assert property (@(posedge i_clk) disable iff (i_rst)
                     (i_instr_valid && !i_next_ready) |=> (i_instr_valid || i_flush_in))
        else $error("instruction lost while the next stage was not ready");

    // Hazard holds the instruction instead of dropping it
    assert property (@(posedge i_clk) disable iff (i_rst)
                     (i_instr_valid && i_raw_hazard) |=> (i_instr_valid || i_flush_in))
        else $error("instruction lost during a RAW hazard");

endmodule

bind exec_control exec_stage_properties u_properties (
    .i_clk(i_clk), .i_rst(i_rst), .i_next_ready(i_next_ready), .i_flush_in(i_flush),
    .i_instr_valid(instr_valid), .i_raw_hazard(raw_hazard), .i_flush_out(o_flush)
);

// ==== bench/exec_stage_tb.sv ====
`timescale 1ns/100ps

module exec_stage_tb;

    localparam int EXEC_TIMEOUT = 32;
    localparam int FIELD_CNT = 21;

    logic i_clk;
    logic i_rst;
    logic i_submit;
    logic i_flush;
    exec_types_pkg::exec_ctrl_t i_ctrl;
    logic [cpu_cfg_pkg::RW-1:0] i_imm;
    logic i_jmp_predict;
    logic i_next_ready;
    logic [cpu_cfg_pkg::REGNO-1:0] i_reg_we;
    logic [cpu_cfg_pkg::RW-1:0] i_reg_data;
    logic o_ready;
    logic o_flush;
    logic o_pc_update;
    logic [cpu_cfg_pkg::RW-1:0] o_exec_pc;
    exec_types_pkg::exec_result_t o_result;
    logic o_submit;
    logic [cpu_cfg_pkg::RW-1:0] o_dbg_r0;
    logic [cpu_cfg_pkg::RW-1:0] o_dbg_pc;

    // Fields of the current trace line, column order as in the trace file
    logic [15:0] f [FIELD_CNT];
    logic [15:0] pc_model;
    int checks;
    int errors;
    bit aborted;

    exec_stage i_exec_stage (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(i_submit), .i_flush(i_flush),
        .i_ctrl(i_ctrl), .i_imm(i_imm), .i_jmp_predict(i_jmp_predict),
        .i_next_ready(i_next_ready), .i_reg_we(i_reg_we), .i_reg_data(i_reg_data),
        .o_ready(o_ready), .o_flush(o_flush), .o_pc_update(o_pc_update),
        .o_exec_pc(o_exec_pc), .o_result(o_result), .o_submit(o_submit),
        .o_dbg_r0(o_dbg_r0), .o_dbg_pc(o_dbg_pc)
    );

    always #50 i_clk = ~i_clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    function automatic exec_types_pkg::exec_ctrl_t make_ctrl();
        exec_types_pkg::exec_ctrl_t c;
        c = '0;
        c.alu_mode = f[1][2:0];
        c.l_sel = f[2][2:0];
        c.r_sel = f[3][2:0];
        c.r_bus_imm = f[4][0];
        c.carry_en = f[6][0];
        c.flags_we = f[7][0];
        c.rf_we = f[8][7:0];
        c.jump_code = f[9][4:0];
        c.mem_access = f[10][0];
        c.mem_we = f[11][0];
        c.used_ops = f[12][1:0];
        c.pc_inc = f[13][0];
        c.pc_load = f[14][0];
        return c;
    endfunction

    // Returns at the negedge of the cycle in which the instruction executes
    task automatic wait_exec(output bit seen);
        int t;
        seen = 1'b0;
        t = 0;
        while (!seen && t < EXEC_TIMEOUT) begin
            @(negedge i_clk);
            seen = o_pc_update;
            t++;
        end
    endtask

    task automatic write_back();
        @(posedge i_clk);
        i_reg_we <= f[8][7:0];
        i_reg_data <= f[5];
        @(posedge i_clk);
        i_reg_we <= '0;
        @(negedge i_clk);
        check("o_dbg_r0", o_dbg_r0, f[20]);
    endtask

    // Kind 2 stalls the next stage, kind 4 waits on a RAW hazard
    task automatic run_instr(input int kind);
        int stall;
        bit seen;
        exec_types_pkg::exec_ctrl_t ld_ctrl;
        if (kind == 4) begin
            // Load to the register read below so its result is pending on o_result
            ld_ctrl = '0;
            ld_ctrl.alu_mode = cpu_cfg_pkg::ALU_PASS_R;
            ld_ctrl.r_bus_imm = 1'b1;
            ld_ctrl.rf_we = 8'(1 << f[3][2:0]);
            ld_ctrl.mem_access = 1'b1;
            @(posedge i_clk);
            i_ctrl <= ld_ctrl;
            i_submit <= 1'b1;
            wait_exec(seen);
            if (!seen) begin
                errors++;
                aborted = 1'b1;
                $display("Timeout: the load ahead of the RAW hazard was never executed");
                return;
            end
        end
        @(posedge i_clk);
        i_ctrl <= make_ctrl();
        i_imm <= f[5];
        i_jmp_predict <= f[15][0];
        i_submit <= 1'b1;
        if (kind == 2) begin
            i_next_ready <= 1'b0;
        end
        if (kind == 4) begin
            i_reg_we <= 8'(1 << f[3][2:0]);
            i_reg_data <= f[5];
        end
        stall = (kind == 2) ? $urandom_range(6, 1) : (kind == 4) ? 1 : 0;
        for (int i = 0; i < stall; i++) begin
            @(negedge i_clk);
            check("o_ready", o_ready, 0);
            check("o_pc_update", o_pc_update, 0);
            @(posedge i_clk);
            // Instruction now lives only in the hold register
            i_submit <= 1'b0;
            i_reg_we <= '0;
        end
        i_next_ready <= 1'b1;
        wait_exec(seen);
        if (!seen) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: the instruction was never executed");
        end else begin
            check("o_exec_pc", o_exec_pc, pc_model);
            @(posedge i_clk);
            i_submit <= 1'b0;
            i_ctrl <= '0;
            i_imm <= '0;
            @(negedge i_clk);
            check("o_submit", o_submit, 1);
            check("o_result.data", o_result.data, f[16]);
            check("o_result.addr", o_result.addr, f[17]);
            check("o_result.reg_we", o_result.reg_we, f[8]);
            check("o_result.mem_access", o_result.mem_access, f[10]);
            check("o_result.mem_we", o_result.mem_we, f[11]);
            check("o_flush", o_flush, f[18]);
            check("o_dbg_pc", o_dbg_pc, f[19]);
            check("o_dbg_r0", o_dbg_r0, f[20]);
            check("o_pc_update", o_pc_update, 0);
            pc_model = f[19];
        end
    endtask

    task automatic flushed_instr();
        @(posedge i_clk);
        i_ctrl <= make_ctrl();
        i_imm <= f[5];
        i_submit <= 1'b1;
        i_flush <= 1'b1;
        @(negedge i_clk);
        check("o_pc_update", o_pc_update, 0);
        @(posedge i_clk);
        i_submit <= 1'b0;
        i_flush <= 1'b0;
        i_ctrl <= '0;
        @(negedge i_clk);
        check("o_submit", o_submit, 0);
        check("o_dbg_pc", o_dbg_pc, f[19]);
    endtask

    initial begin
        int fd;
        int n;
        string line;
        void'($urandom(32'h8538_49f9));
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_submit = 1'b0;
        i_flush = 1'b0;
        i_ctrl = '0;
        i_imm = '0;
        i_jmp_predict = 1'b0;
        i_next_ready = 1'b1;
        i_reg_we = '0;
        i_reg_data = '0;
        pc_model = '0;
        checks = 0;
        errors = 0;
        aborted = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        fd = $fopen("bench/exec_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file bench/exec_trace.txt");
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                            f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
                if (n != FIELD_CNT) begin
                    errors++;
                    $display("Trace line has %0d fields instead of %0d", n, FIELD_CNT);
                end else if (f[0] == 0) begin
                    write_back();
                end else if (f[0] == 3) begin
                    flushed_instr();
                end else begin
                    run_instr(int'(f[0]));
                end
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/exec_trace.txt ====
# kind(0 wb,1 instr,2 stall,3 flushed,4 hazard) mode l r imm_sel imm carry_en flags_we rf_we
# jump pc_inc pc_load predict | exp_data exp_addr exp_flush exp_pc exp_r0 (all hex)
# full column order: kind mode l r rbi imm cen fwe rfwe jcode macc mwe used pinc pload pred
#                    data addr flush pc r0
0 0 0 0 0 1234 0 0 01 00 0 0 0 0 0 0 0000 0000 0 0000 1234
0 0 0 0 0 00ff 0 0 02 00 0 0 0 0 0 0 0000 0000 0 0000 1234
0 0 0 0 0 8000 0 0 04 00 0 0 0 0 0 0 0000 0000 0 0000 1234
0 0 0 0 0 7fff 0 0 08 00 0 0 0 0 0 0 0000 0000 0 0000 1234
1 7 0 1 0 0000 0 1 00 00 0 0 3 1 0 0 00ff 00ff 0 0001 1234
1 0 3 3 0 0000 0 1 00 00 0 0 3 1 0 0 fffe fffe 0 0002 1234
1 0 2 0 1 8000 0 1 00 00 0 0 3 1 0 0 0000 0000 0 0003 1234
1 0 0 0 1 0001 1 1 00 00 0 0 3 1 0 0 1236 1236 0 0004 1234
1 1 1 0 0 0000 0 1 00 00 0 0 3 1 0 0 eecb eecb 0 0005 1234
1 1 0 0 1 0034 1 0 00 00 0 0 3 1 0 0 11ff 11ff 0 0006 1234
1 2 0 1 0 0000 0 0 00 00 0 0 3 1 0 0 0034 0034 0 0007 1234
1 3 1 0 1 ff00 0 0 00 00 0 0 3 1 0 0 ffff ffff 0 0008 1234
1 4 0 3 0 0000 0 0 00 00 0 0 3 1 0 0 6dcb 6dcb 0 0009 1234
1 5 2 0 0 0000 0 0 00 00 0 0 3 1 0 0 0000 0000 0 000a 1234
1 6 0 0 0 0000 0 0 00 00 0 0 3 1 0 0 091a 091a 0 000b 1234
1 0 1 3 1 0010 0 0 00 00 1 1 3 1 0 0 7fff 010f 0 000c 1234
1 7 0 0 1 0040 0 0 00 11 0 0 0 0 0 1 0040 0040 0 0040 1234
1 7 0 0 1 0080 0 0 00 12 0 0 0 0 0 1 0080 0080 1 0041 1234
1 7 0 0 1 0100 0 0 00 13 0 0 0 0 0 0 0100 0100 1 0100 1234
1 7 0 0 1 0200 0 0 00 14 0 0 0 0 0 0 0200 0200 0 0101 1234
1 7 0 0 1 0300 0 0 00 15 0 0 0 0 0 0 0300 0300 1 0300 1234
1 7 0 0 1 0400 0 0 00 16 0 0 0 0 0 1 0400 0400 1 0301 1234
1 7 0 0 1 0500 0 0 00 17 0 0 0 0 0 1 0500 0500 0 0500 1234
1 7 0 0 1 0600 0 0 00 18 0 0 0 0 0 0 0600 0600 0 0501 1234
1 7 0 0 1 0700 0 0 00 19 0 0 0 0 0 1 0700 0700 1 0502 1234
1 7 0 0 1 0800 0 0 00 10 0 0 0 0 0 0 0800 0800 1 0800 1234
3 7 0 0 1 0000 0 1 00 00 0 0 0 0 1 0 0000 0000 0 0800 1234
1 7 0 0 1 0900 0 0 00 12 0 0 0 0 0 0 0900 0900 0 0801 1234
2 0 0 0 1 0001 0 1 00 00 0 0 3 1 0 0 1235 1235 0 0802 1234
2 7 0 0 1 0a00 0 0 00 19 0 0 0 0 0 1 0a00 0a00 0 0a00 1234
1 0 0 0 1 0000 0 0 10 00 0 0 3 1 0 0 1234 1234 0 0a01 1234
4 7 0 4 0 5a5a 0 0 00 00 0 0 2 1 0 0 5a5a 5a5a 0 0a02 1234
0 0 0 0 0 00aa 0 0 01 00 0 0 0 0 0 0 0000 0000 0 0000 00aa

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [cpu_cfg_pkg::RW-1:0]            i_l,
    input  logic [cpu_cfg_pkg::RW-1:0]            i_r,
    input  logic [cpu_cfg_pkg::RW-1:0]            i_imm,
    input  logic                                  i_r_bus_imm,
    input  logic [cpu_cfg_pkg::ALU_MODE_W-1:0]    i_mode,
    input  logic                                  i_carry,
    output logic [cpu_cfg_pkg::RW-1:0]            o_out,
    output logic [cpu_cfg_pkg::FLAG_CNT-1:0]      o_flags
);
    localparam int W = cpu_cfg_pkg::RW;

    logic [W-1:0] r_bus;
    logic [W:0]   wide;
    logic         carry;
    logic         ovf;

    // Right operand comes from the immediate or the register file
    assign r_bus = i_r_bus_imm ? i_imm : i_r;

    always_comb begin
        wide = '0;
        carry = 1'b0;
        ovf = 1'b0;
        case (i_mode)
            cpu_cfg_pkg::ALU_ADD: begin
                wide = {1'b0, i_l} + {1'b0, r_bus} + (W+1)'(i_carry);
                carry = wide[W];
                ovf = (i_l[W-1] == r_bus[W-1]) && (wide[W-1] != i_l[W-1]);
            end
            cpu_cfg_pkg::ALU_SUB: begin
                // Bit W of the difference is the borrow
                wide = {1'b0, i_l} - {1'b0, r_bus} - (W+1)'(i_carry);
                carry = wide[W];
                ovf = (i_l[W-1] != r_bus[W-1]) && (wide[W-1] != i_l[W-1]);
            end
            cpu_cfg_pkg::ALU_AND:    wide = {1'b0, i_l & r_bus};
            cpu_cfg_pkg::ALU_OR:     wide = {1'b0, i_l | r_bus};
            cpu_cfg_pkg::ALU_XOR:    wide = {1'b0, i_l ^ r_bus};
            cpu_cfg_pkg::ALU_SHL: begin
                wide = {1'b0, i_l[W-2:0], 1'b0};
                carry = i_l[W-1];
            end
            cpu_cfg_pkg::ALU_SHR: begin
                wide = {2'b00, i_l[W-1:1]};
                carry = i_l[0];
            end
            cpu_cfg_pkg::ALU_PASS_R: wide = {1'b0, r_bus};
            default:                 wide = '0;
        endcase
    end

    assign o_out = wide[W-1:0];

    assign o_flags[cpu_cfg_pkg::FLAG_C] = carry;
    assign o_flags[cpu_cfg_pkg::FLAG_Z] = (o_out == '0);
    assign o_flags[cpu_cfg_pkg::FLAG_N] = o_out[W-1];
    assign o_flags[cpu_cfg_pkg::FLAG_O] = ovf;
    assign o_flags[cpu_cfg_pkg::FLAG_P] = ~^o_out;

endmodule

// ==== logic/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    // Datapath and register file geometry
    localparam int RW = 16;
    localparam int REGNO = 8;
    localparam int REGNO_LOG = 3;

    // ALU operation select
    localparam int ALU_MODE_W = 3;
    localparam logic [ALU_MODE_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_MODE_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_MODE_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_MODE_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_MODE_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_MODE_W-1:0] ALU_SHL    = 3'd5;
    localparam logic [ALU_MODE_W-1:0] ALU_SHR    = 3'd6;
    localparam logic [ALU_MODE_W-1:0] ALU_PASS_R = 3'd7;

    // Flag vector layout
    localparam int FLAG_CNT = 5;
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_O = 3;
    // Set when the result holds an even number of ones
    localparam int FLAG_P = 4;

    // Jump condition codes, bit 4 marks a jump
    localparam int JUMP_CODE_W = 5;
    localparam int JUMP_EN_BIT = 4;
    localparam logic [JUMP_CODE_W-1:0] JMP_UNCOND = 5'h10;
    localparam logic [JUMP_CODE_W-1:0] JMP_CARRY  = 5'h11;
    localparam logic [JUMP_CODE_W-1:0] JMP_EQ     = 5'h12;
    localparam logic [JUMP_CODE_W-1:0] JMP_LT     = 5'h13;
    localparam logic [JUMP_CODE_W-1:0] JMP_GT     = 5'h14;
    localparam logic [JUMP_CODE_W-1:0] JMP_LE     = 5'h15;
    localparam logic [JUMP_CODE_W-1:0] JMP_GE     = 5'h16;
    localparam logic [JUMP_CODE_W-1:0] JMP_NE     = 5'h17;
    localparam logic [JUMP_CODE_W-1:0] JMP_OVF    = 5'h18;
    localparam logic [JUMP_CODE_W-1:0] JMP_PAR    = 5'h19;

endpackage

// ==== logic/exec_control.sv ====
`timescale 1ns/100ps

module exec_control (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_submit,
    input  logic                                  i_flush,
    input  logic                                  i_next_ready,
    input  logic                                  i_jmp_predict,
    input  exec_types_pkg::exec_ctrl_t            i_ctrl,
    input  logic [cpu_cfg_pkg::FLAG_CNT-1:0]      i_flags_d,
    input  logic [cpu_cfg_pkg::REGNO-1:0]         i_pend_we,
    input  logic                                  i_pend_submit,
    output logic                                  o_ready,
    output logic                                  o_exec_submit,
    output logic                                  o_flush,
    output exec_types_pkg::pc_cmd_t               o_pc_cmd,
    output logic                                  o_carry_in,
    output logic [cpu_cfg_pkg::FLAG_CNT-1:0]      o_flags_q
);
    logic in_valid;
    logic hold_valid;
    logic instr_valid;
    logic raw_hazard;
    logic jump_valid;
    logic jump_taken;

    // Operand reads a register whose result has not left this stage yet
    assign raw_hazard = ((i_ctrl.used_ops[0] & i_pend_we[i_ctrl.l_sel]) |
                         (i_ctrl.used_ops[1] & i_pend_we[i_ctrl.r_sel])) &
                        (i_pend_submit | ~i_next_ready);

    assign in_valid = i_submit & ~i_flush;
    assign instr_valid = in_valid | (hold_valid & ~i_submit & ~i_flush);
    assign o_exec_submit = instr_valid & i_next_ready & ~raw_hazard;
    assign o_ready = o_exec_submit | ~instr_valid;

    // Stalled instruction stays pending until executed or flushed
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (i_flush | o_exec_submit) begin
            hold_valid <= 1'b0;
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flags_q <= '0;
        end else if (o_exec_submit & i_ctrl.flags_we) begin
            o_flags_q <= i_flags_d;
        end
    end

    assign o_carry_in = o_flags_q[cpu_cfg_pkg::FLAG_C] & i_ctrl.carry_en;

    // Condition evaluated against flags from earlier instructions
    assign jump_valid = i_ctrl.jump_code[cpu_cfg_pkg::JUMP_EN_BIT];

    always_comb begin
        case (i_ctrl.jump_code)
            cpu_cfg_pkg::JMP_UNCOND: jump_taken = 1'b1;
            cpu_cfg_pkg::JMP_CARRY:  jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_C];
            cpu_cfg_pkg::JMP_EQ:     jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_Z];
            cpu_cfg_pkg::JMP_LT:     jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_N];
            cpu_cfg_pkg::JMP_GT:     jump_taken = ~(o_flags_q[cpu_cfg_pkg::FLAG_N] |
                                                    o_flags_q[cpu_cfg_pkg::FLAG_Z]);
            cpu_cfg_pkg::JMP_LE:     jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_N] |
                                                  o_flags_q[cpu_cfg_pkg::FLAG_Z];
            cpu_cfg_pkg::JMP_GE:     jump_taken = ~o_flags_q[cpu_cfg_pkg::FLAG_N];
            cpu_cfg_pkg::JMP_NE:     jump_taken = ~o_flags_q[cpu_cfg_pkg::FLAG_Z];
            cpu_cfg_pkg::JMP_OVF:    jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_O];
            cpu_cfg_pkg::JMP_PAR:    jump_taken = o_flags_q[cpu_cfg_pkg::FLAG_P];
            default:                 jump_taken = 1'b0;
        endcase
    end

    assign o_pc_cmd.inc = (i_ctrl.pc_inc | (jump_valid & ~jump_taken)) & o_exec_submit;
    assign o_pc_cmd.load = (i_ctrl.pc_load | (jump_valid & jump_taken)) & o_exec_submit;

    // Wrong prediction kills the younger stages one cycle later
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= o_exec_submit & jump_valid & (jump_taken ^ i_jmp_predict);
        end
    end

endmodule

// ==== logic/exec_result_reg.sv ====
`timescale 1ns/100ps

module exec_result_reg (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_exec_submit,
    input  exec_types_pkg::exec_ctrl_t       i_ctrl,
    input  logic [cpu_cfg_pkg::RW-1:0]       i_alu,
    input  logic [cpu_cfg_pkg::RW-1:0]       i_r_data,
    output exec_types_pkg::exec_result_t     o_result,
    output logic                             o_submit
);

    // Valid for one cycle per executed instruction
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
            o_result <= '0;
        end else begin
            o_submit <= i_exec_submit;
            if (i_exec_submit) begin
                // Stores carry the register value, the ALU gives the address
                o_result.addr <= i_alu;
                o_result.data <= i_ctrl.mem_access ? i_r_data : i_alu;
                o_result.reg_we <= i_ctrl.rf_we;
                o_result.mem_access <= i_ctrl.mem_access;
                o_result.mem_we <= i_ctrl.mem_we;
            end
        end
    end

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_submit,
    input  logic                                i_flush,
    input  exec_types_pkg::exec_ctrl_t          i_ctrl,
    input  logic [cpu_cfg_pkg::RW-1:0]          i_imm,
    input  logic                                i_jmp_predict,
    input  logic                                i_next_ready,
    input  logic [cpu_cfg_pkg::REGNO-1:0]       i_reg_we,
    input  logic [cpu_cfg_pkg::RW-1:0]          i_reg_data,
    output logic                                o_ready,
    output logic                                o_flush,
    output logic                                o_pc_update,
    output logic [cpu_cfg_pkg::RW-1:0]          o_exec_pc,
    output exec_types_pkg::exec_result_t        o_result,
    output logic                                o_submit,
    output logic [cpu_cfg_pkg::RW-1:0]          o_dbg_r0,
    output logic [cpu_cfg_pkg::RW-1:0]          o_dbg_pc
);
    exec_types_pkg::pc_cmd_t              pc_cmd;
    logic                                 exec_submit;
    logic                                 carry_in;
    logic [cpu_cfg_pkg::FLAG_CNT-1:0]     flags_d;
    logic [cpu_cfg_pkg::RW-1:0]           reg_l;
    logic [cpu_cfg_pkg::RW-1:0]           reg_r;
    logic [cpu_cfg_pkg::RW-1:0]           alu_bus;

    // Fetch sees the PC before this instruction updates it
    assign o_pc_update = exec_submit;
    assign o_dbg_pc = o_exec_pc;

    exec_control i_control (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(i_submit), .i_flush(i_flush),
        .i_next_ready(i_next_ready), .i_jmp_predict(i_jmp_predict), .i_ctrl(i_ctrl),
        .i_flags_d(flags_d), .i_pend_we(o_result.reg_we), .i_pend_submit(o_submit),
        .o_ready(o_ready), .o_exec_submit(exec_submit), .o_flush(o_flush),
        .o_pc_cmd(pc_cmd), .o_carry_in(carry_in), .o_flags_q()
    );

    reg_file i_reg_file (
        .i_clk(i_clk), .i_rst(i_rst), .i_we(i_reg_we), .i_d(i_reg_data),
        .i_l_sel(i_ctrl.l_sel), .i_r_sel(i_ctrl.r_sel),
        .o_l(reg_l), .o_r(reg_r), .o_r0(o_dbg_r0)
    );

    alu i_alu (
        .i_l(reg_l), .i_r(reg_r), .i_imm(i_imm), .i_r_bus_imm(i_ctrl.r_bus_imm),
        .i_mode(i_ctrl.alu_mode), .i_carry(carry_in), .o_out(alu_bus), .o_flags(flags_d)
    );

    pc_unit i_pc_unit (
        .i_clk(i_clk), .i_rst(i_rst), .i_cmd(pc_cmd), .i_bus(alu_bus), .o_pc(o_exec_pc)
    );

    exec_result_reg i_result_reg (
        .i_clk(i_clk), .i_rst(i_rst), .i_exec_submit(exec_submit), .i_ctrl(i_ctrl),
        .i_alu(alu_bus), .i_r_data(reg_r), .o_result(o_result), .o_submit(o_submit)
    );

endmodule

// ==== logic/exec_types_pkg.sv ====
package exec_types_pkg;

    // Decoded instruction as delivered by the decode stage
    typedef struct packed {
        logic                                    pc_inc;
        logic                                    pc_load;
        logic                                    r_bus_imm;
        logic [cpu_cfg_pkg::ALU_MODE_W-1:0]      alu_mode;
        logic                                    carry_en;
        logic                                    flags_we;
        logic [cpu_cfg_pkg::REGNO_LOG-1:0]       l_sel;
        logic [cpu_cfg_pkg::REGNO_LOG-1:0]       r_sel;
        logic [cpu_cfg_pkg::REGNO-1:0]           rf_we;
        logic [cpu_cfg_pkg::JUMP_CODE_W-1:0]     jump_code;
        logic                                    mem_access;
        logic                                    mem_we;
        // Bit 0 left operand, bit 1 right operand
        logic [1:0]                              used_ops;
    } exec_ctrl_t;

    // Work handed to the memory/writeback stage
    typedef struct packed {
        logic [cpu_cfg_pkg::RW-1:0]    data;
        logic [cpu_cfg_pkg::RW-1:0]    addr;
        logic [cpu_cfg_pkg::REGNO-1:0] reg_we;
        logic                          mem_access;
        logic                          mem_we;
    } exec_result_t;

    // PC update request, already qualified by execution
    typedef struct packed {
        logic inc;
        logic load;
    } pc_cmd_t;

endpackage

// ==== logic/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  exec_types_pkg::pc_cmd_t     i_cmd,
    input  logic [cpu_cfg_pkg::RW-1:0]  i_bus,
    output logic [cpu_cfg_pkg::RW-1:0]  o_pc
);

    // Jump target from the ALU wins over sequential step
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_cmd.load) begin
            o_pc <= i_bus;
        end else if (i_cmd.inc) begin
            o_pc <= o_pc + 1'b1;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic [cpu_cfg_pkg::REGNO-1:0]        i_we,
    input  logic [cpu_cfg_pkg::RW-1:0]           i_d,
    input  logic [cpu_cfg_pkg::REGNO_LOG-1:0]    i_l_sel,
    input  logic [cpu_cfg_pkg::REGNO_LOG-1:0]    i_r_sel,
    output logic [cpu_cfg_pkg::RW-1:0]           o_l,
    output logic [cpu_cfg_pkg::RW-1:0]           o_r,
    output logic [cpu_cfg_pkg::RW-1:0]           o_r0
);
    logic [cpu_cfg_pkg::RW-1:0] regs [cpu_cfg_pkg::REGNO];

    // One-hot enables, several registers may load the same word
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < cpu_cfg_pkg::REGNO; i++) begin
            if (i_rst) begin
                regs[i] <= '0;
            end else if (i_we[i]) begin
                regs[i] <= i_d;
            end
        end
    end

    // Reads see the old value during a write
    assign o_l = regs[i_l_sel];
    assign o_r = regs[i_r_sel];
    assign o_r0 = regs[0];

endmodule

// ==== run_verilator.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_stage_tb \
    -f vlog.f -o exec_stage_sim

status=0
./obj_dir/exec_stage_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

// ==== vlog.f ====
logic/cpu_cfg_pkg.sv
logic/exec_types_pkg.sv
logic/exec_control.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/exec_result_reg.sv
logic/exec_stage.sv
bench/exec_stage_properties.sv
bench/exec_stage_tb.sv
